//--- csr_unit.f
rtl/csr_pkg.sv
rtl/csr_timer.sv
rtl/csr_trap_ctrl.sv
rtl/csr_regfile.sv
rtl/csr_unit.sv
sim/csr_unit_tb.sv

//--- rtl/csr_pkg.sv
package csr_pkg;

    typedef logic [31:0] word_t;
    typedef logic [13:0] csr_addr_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [8:0]  esubcode_t;
    typedef logic [3:0]  cause_t;

    // Cause numbers as reported by the pipeline
    localparam cause_t CAUSE_PIL  = 4'd0;
    localparam cause_t CAUSE_PIS  = 4'd1;
    localparam cause_t CAUSE_PIF  = 4'd2;
    localparam cause_t CAUSE_PME  = 4'd3;
    localparam cause_t CAUSE_PPI  = 4'd4;
    localparam cause_t CAUSE_ADEF = 4'd5;
    localparam cause_t CAUSE_ADEM = 4'd6;
    localparam cause_t CAUSE_ALE  = 4'd7;
    localparam cause_t CAUSE_SYS  = 4'd8;
    localparam cause_t CAUSE_BRK  = 4'd9;
    localparam cause_t CAUSE_INE  = 4'd10;
    localparam cause_t CAUSE_IPE  = 4'd11;
    localparam cause_t CAUSE_FPD  = 4'd12;
    localparam cause_t CAUSE_FPE  = 4'd13;

    localparam csr_addr_t CSR_CRMD   = 14'h000;
    localparam csr_addr_t CSR_PRMD   = 14'h001;
    localparam csr_addr_t CSR_EUEN   = 14'h002;
    localparam csr_addr_t CSR_ECFG   = 14'h004;
    localparam csr_addr_t CSR_ESTAT  = 14'h005;
    localparam csr_addr_t CSR_ERA    = 14'h006;
    localparam csr_addr_t CSR_BADV   = 14'h007;
    localparam csr_addr_t CSR_EENTRY = 14'h00c;
    localparam csr_addr_t CSR_CPUID  = 14'h020;
    localparam csr_addr_t CSR_SAVE0  = 14'h030;
    localparam csr_addr_t CSR_SAVE1  = 14'h031;
    localparam csr_addr_t CSR_SAVE2  = 14'h032;
    localparam csr_addr_t CSR_SAVE3  = 14'h033;
    localparam csr_addr_t CSR_TID    = 14'h040;
    localparam csr_addr_t CSR_TCFG   = 14'h041;
    localparam csr_addr_t CSR_TVAL   = 14'h042;
    localparam csr_addr_t CSR_TICLR  = 14'h044;
    localparam csr_addr_t CSR_LLBCTL = 14'h060;

    typedef struct packed {
        logic      en;
        csr_addr_t addr;
        word_t     data;
        logic      is_llsc;  // LL/SC update of LLBIT
    } csr_wr_t;

    typedef struct packed {
        logic   valid;
        word_t  pc;
        logic   exc_valid;
        cause_t cause;
        word_t  badv;
    } commit_t;

    typedef struct packed {
        logic      valid;
        ecode_t    ecode;
        esubcode_t esubcode;
        word_t     era;
        logic      badv_we;
        word_t     badv;
    } trap_t;

    typedef struct packed {
        logic        crmd_ie;
        word_t       eentry;
        word_t       era;
        logic [12:0] lie;
        logic [12:0] is;
    } csr_ctrl_t;

    typedef struct packed {
        word_t tcfg;
        word_t tval;
    } timer_csr_t;

    typedef struct packed {
        logic  valid;
        word_t target;
    } redirect_t;

endpackage

//--- rtl/csr_regfile.sv
module csr_regfile #(
    parameter int CORE_ID = 0
) (
    input  logic                clk,
    input  logic                rst,
    input  csr_pkg::csr_wr_t    wr_i,
    input  csr_pkg::trap_t      trap_i,
    input  logic                ertn_i,
    input  logic [7:0]          hwi_i,
    input  logic                ipi_i,
    input  logic                ti_i,
    input  csr_pkg::timer_csr_t timer_i,
    input  logic                rd_en_i,
    input  csr_pkg::csr_addr_t  rd_addr_i,
    output csr_pkg::word_t      rd_data_o,
    output csr_pkg::csr_ctrl_t  ctrl_o,
    output logic [1:0]          plv_o,
    output logic                llbit_o
);
    import csr_pkg::*;

    localparam word_t CPUID_VAL = word_t'(CORE_ID);
    localparam csr_addr_t SAVE_ADDR [4] = '{CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3};

    word_t crmd_q;
    word_t prmd_q;
    word_t euen_q;
    word_t ecfg_q;
    word_t estat_q;
    word_t era_q;
    word_t badv_q;
    word_t eentry_q;
    word_t tid_q;
    word_t save_q [4];
    logic  llbit_q;
    logic  klo_q;
    logic  csr_we;

    // LL/SC updates only touch LLBIT
    assign csr_we = wr_i.en && !wr_i.is_llsc;

    function automatic logic wr_hit(input csr_addr_t addr);
        return csr_we && (wr_i.addr == addr);
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            crmd_q <= 32'h0000_0008;  // DA = 1
        end else if (trap_i.valid) begin
            crmd_q[2:0] <= 3'b000;  // IE, PLV
        end else if (ertn_i) begin
            crmd_q[2:0] <= prmd_q[2:0];
        end else if (wr_hit(CSR_CRMD)) begin
            crmd_q[8:0] <= wr_i.data[8:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prmd_q <= '0;
        end else if (trap_i.valid) begin
            prmd_q[2:0] <= crmd_q[2:0];
        end else if (wr_hit(CSR_PRMD)) begin
            prmd_q[2:0] <= wr_i.data[2:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            euen_q <= '0;
            ecfg_q <= '0;
            eentry_q <= '0;
        end else begin
            if (wr_hit(CSR_EUEN)) begin
                euen_q[0] <= wr_i.data[0];
            end
            if (wr_hit(CSR_ECFG)) begin
                ecfg_q[12:11] <= wr_i.data[12:11];
                ecfg_q[9:0] <= wr_i.data[9:0];
            end
            if (wr_hit(CSR_EENTRY)) begin
                eentry_q[31:6] <= wr_i.data[31:6];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            estat_q <= '0;
        end else begin
            estat_q[9:2] <= hwi_i;
            estat_q[11] <= ti_i;
            estat_q[12] <= ipi_i;
            if (trap_i.valid) begin
                estat_q[21:16] <= trap_i.ecode;
                estat_q[30:22] <= trap_i.esubcode;
            end else if (wr_hit(CSR_ESTAT)) begin
                estat_q[1:0] <= wr_i.data[1:0];  // Software interrupts
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            era_q <= '0;
        end else if (trap_i.valid) begin
            era_q <= trap_i.era;
        end else if (wr_hit(CSR_ERA)) begin
            era_q <= wr_i.data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            badv_q <= '0;
        end else if (trap_i.valid && trap_i.badv_we) begin
            badv_q <= trap_i.badv;
        end else if (wr_hit(CSR_BADV)) begin
            badv_q <= wr_i.data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tid_q <= CPUID_VAL;
            for (int i = 0; i < 4; i++) begin
                save_q[i] <= '0;
            end
        end else begin
            if (wr_hit(CSR_TID)) begin
                tid_q <= wr_i.data;
            end
            for (int i = 0; i < 4; i++) begin
                if (wr_hit(SAVE_ADDR[i])) begin
                    save_q[i] <= wr_i.data;
                end
            end
        end
    end

    // LLBCTL holds LLBIT, KLO and the write-only WCLLB
    always_ff @(posedge clk) begin
        if (rst) begin
            llbit_q <= 1'b0;
            klo_q <= 1'b0;
        end else if (ertn_i) begin
            if (!klo_q) begin
                llbit_q <= 1'b0;
            end
            klo_q <= 1'b0;
        end else if (wr_i.en && wr_i.is_llsc) begin
            llbit_q <= wr_i.data[0];
        end else if (wr_hit(CSR_LLBCTL)) begin
            if (wr_i.data[1]) begin
                llbit_q <= 1'b0;
            end
            klo_q <= wr_i.data[2];
        end
    end

    always_comb begin
        rd_data_o = '0;
        if (!rst && rd_en_i) begin
            case (rd_addr_i)
                CSR_CRMD:   rd_data_o = crmd_q;
                CSR_PRMD:   rd_data_o = prmd_q;
                CSR_EUEN:   rd_data_o = euen_q;
                CSR_ECFG:   rd_data_o = ecfg_q;
                CSR_ESTAT:  rd_data_o = estat_q;
                CSR_ERA:    rd_data_o = era_q;
                CSR_BADV:   rd_data_o = badv_q;
                CSR_EENTRY: rd_data_o = eentry_q;
                CSR_CPUID:  rd_data_o = CPUID_VAL;
                CSR_SAVE0:  rd_data_o = save_q[0];
                CSR_SAVE1:  rd_data_o = save_q[1];
                CSR_SAVE2:  rd_data_o = save_q[2];
                CSR_SAVE3:  rd_data_o = save_q[3];
                CSR_LLBCTL: rd_data_o = {29'd0, klo_q, 1'b0, llbit_q};
                CSR_TID:    rd_data_o = tid_q;
                CSR_TCFG:   rd_data_o = timer_i.tcfg;
                CSR_TVAL:   rd_data_o = timer_i.tval;
                CSR_TICLR:  rd_data_o = '0;
                default:    rd_data_o = '0;
            endcase
        end
    end

    assign ctrl_o.crmd_ie = crmd_q[2];
    assign ctrl_o.eentry  = {eentry_q[31:6], 6'd0};
    assign ctrl_o.era     = era_q;
    assign ctrl_o.lie     = {ecfg_q[12:11], 1'b0, ecfg_q[9:0]};
    assign ctrl_o.is      = estat_q[12:0];

    assign plv_o   = crmd_q[1:0];
    assign llbit_o = llbit_q;

endmodule

//--- rtl/csr_timer.sv
module csr_timer (
    input  logic                clk,
    input  logic                rst,
    input  csr_pkg::csr_wr_t    wr_i,
    output csr_pkg::timer_csr_t timer_o,
    output logic                ti_o
);
    import csr_pkg::*;

    word_t tcfg_q;
    word_t tval_q;
    logic  ti_q;
    logic  tcfg_we;
    logic  ticlr_we;
    logic  fire;
    word_t reload;

    assign tcfg_we  = wr_i.en && !wr_i.is_llsc && (wr_i.addr == CSR_TCFG);
    assign ticlr_we = wr_i.en && !wr_i.is_llsc && (wr_i.addr == CSR_TICLR) && wr_i.data[0];
    assign reload   = {tcfg_q[31:2], 2'b00};

    // Last decrement of an enabled count
    assign fire = tcfg_q[0] && (tval_q == 32'd1) && !tcfg_we;

    always_ff @(posedge clk) begin
        if (rst) begin
            tcfg_q <= '0;  // En = 0
        end else if (tcfg_we) begin
            tcfg_q <= wr_i.data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tval_q <= '1;
        end else if (tcfg_we) begin
            tval_q <= {wr_i.data[31:2], 2'b00};
        end else if (tcfg_q[0]) begin
            if (tval_q != '0) begin
                tval_q <= tval_q - 32'd1;
            end else if (tcfg_q[1]) begin
                tval_q <= reload;  // Periodic
            end
        end
    end

    // Sticky until cleared through TICLR
    always_ff @(posedge clk) begin
        if (rst) begin
            ti_q <= 1'b0;
        end else if (fire) begin
            ti_q <= 1'b1;
        end else if (ticlr_we) begin
            ti_q <= 1'b0;
        end
    end

    assign timer_o.tcfg = tcfg_q;
    assign timer_o.tval = tval_q;
    assign ti_o         = ti_q;

endmodule

//--- rtl/csr_trap_ctrl.sv
module csr_trap_ctrl (
    input  logic               clk,
    input  logic               rst,
    input  csr_pkg::commit_t   commit_i,
    input  logic               ertn_i,
    input  csr_pkg::csr_ctrl_t ctrl_i,
    output csr_pkg::trap_t     trap_o,
    output csr_pkg::redirect_t redirect_o
);
    import csr_pkg::*;

    logic   int_pending;
    logic   take_trap;
    logic   is_call;
    logic   exc_badv_we;
    ecode_t exc_ecode;
    logic   redir_valid_q;
    word_t  redir_target_q;

    assign int_pending = ctrl_i.crmd_ie && (|(ctrl_i.lie & ctrl_i.is));
    assign take_trap   = commit_i.valid && (int_pending || commit_i.exc_valid);
    assign is_call     = commit_i.cause inside {CAUSE_SYS, CAUSE_BRK};

    // Causes that report a faulting address
    assign exc_badv_we = commit_i.cause inside {CAUSE_PIL, CAUSE_PIS, CAUSE_PIF,
                                                CAUSE_PME, CAUSE_PPI, CAUSE_ALE,
                                                CAUSE_ADEF};

    always_comb begin
        case (commit_i.cause)
            CAUSE_PIL:  exc_ecode = 6'h01;
            CAUSE_PIS:  exc_ecode = 6'h02;
            CAUSE_PIF:  exc_ecode = 6'h03;
            CAUSE_PME:  exc_ecode = 6'h04;
            CAUSE_PPI:  exc_ecode = 6'h07;
            CAUSE_ADEF: exc_ecode = 6'h08;
            CAUSE_ADEM: exc_ecode = 6'h08;  // Subcode 1
            CAUSE_ALE:  exc_ecode = 6'h09;
            CAUSE_SYS:  exc_ecode = 6'h0b;
            CAUSE_BRK:  exc_ecode = 6'h0c;
            CAUSE_INE:  exc_ecode = 6'h0d;
            CAUSE_IPE:  exc_ecode = 6'h0e;
            CAUSE_FPD:  exc_ecode = 6'h0f;
            CAUSE_FPE:  exc_ecode = 6'h12;
            default:    exc_ecode = 6'h0d;
        endcase
    end

    // Interrupt takes priority over any exception on the same commit
    always_comb begin
        trap_o.valid    = take_trap;
        trap_o.ecode    = int_pending ? 6'h00 : exc_ecode;
        trap_o.esubcode = (!int_pending && commit_i.cause == CAUSE_ADEM) ? 9'd1 : 9'd0;
        trap_o.era      = (!int_pending && is_call) ? commit_i.pc + 32'd4 : commit_i.pc;
        trap_o.badv_we  = !int_pending && exc_badv_we;
        trap_o.badv     = (commit_i.cause == CAUSE_ADEF) ? commit_i.pc : commit_i.badv;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            redir_valid_q <= 1'b0;
        end else begin
            redir_valid_q <= take_trap || ertn_i;
        end
    end

    // Target sampled in the trap or ERTN cycle
    always_ff @(posedge clk) begin
        if (take_trap) begin
            redir_target_q <= ctrl_i.eentry;
        end else if (ertn_i) begin
            redir_target_q <= ctrl_i.era;
        end
    end

    assign redirect_o.valid  = redir_valid_q;
    assign redirect_o.target = redir_target_q;

endmodule

//--- rtl/csr_unit.sv
module csr_unit #(
    parameter int CORE_ID = 0
) (
    input  logic               clk,
    input  logic               rst,
    input  csr_pkg::commit_t   commit_i,
    input  logic               ertn_i,
    input  csr_pkg::csr_wr_t   csr_wr_i,
    input  logic               csr_rd_en_i,
    input  csr_pkg::csr_addr_t csr_rd_addr_i,
    input  logic [7:0]         hwi_i,
    input  logic               ipi_i,
    output csr_pkg::word_t     csr_rd_data_o,
    output csr_pkg::redirect_t redirect_o,
    output logic [1:0]         plv_o,
    output logic               llbit_o
);
    import csr_pkg::*;

    trap_t      trap;
    csr_ctrl_t  ctrl;
    timer_csr_t timer;
    logic       ti;

    csr_regfile #(
        .CORE_ID(CORE_ID)
    ) csr_regfile_i (
        .clk      (clk),
        .rst      (rst),
        .wr_i     (csr_wr_i),
        .trap_i   (trap),
        .ertn_i   (ertn_i),
        .hwi_i    (hwi_i),
        .ipi_i    (ipi_i),
        .ti_i     (ti),
        .timer_i  (timer),
        .rd_en_i  (csr_rd_en_i),
        .rd_addr_i(csr_rd_addr_i),
        .rd_data_o(csr_rd_data_o),
        .ctrl_o   (ctrl),
        .plv_o    (plv_o),
        .llbit_o  (llbit_o)
    );

    csr_timer csr_timer_i (
        .clk    (clk),
        .rst    (rst),
        .wr_i   (csr_wr_i),
        .timer_o(timer),
        .ti_o   (ti)
    );

    csr_trap_ctrl csr_trap_ctrl_i (
        .clk       (clk),
        .rst       (rst),
        .commit_i  (commit_i),
        .ertn_i    (ertn_i),
        .ctrl_i    (ctrl),
        .trap_o    (trap),
        .redirect_o(redirect_o)
    );

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the CSR unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps -f csr_unit.f \
    --top-module csr_unit_tb -o csr_unit_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/csr_unit_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation binary exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "SIMULATION PASSED"; then
    exit 0
fi
exit 1

//--- sim/csr_cases.txt
# op name operands, all hex. R: addr expected  W: addr data  L: llbit  C: pc exc cause badv ecode
# E: ertn  H: hwi ipi  T: max polls  N: idle cycles  P: plv  B: llbit
R crmd_rst 000 00000008
R cpuid_rst 020 00000005
R tid_rst 040 00000005
R tval_rst 042 ffffffff
P plv_rst 0
B llbit_rst 0
W crmd_w 000 ffffffff
R crmd_mask 000 000001ff
W prmd_w 001 ffffffff
R prmd_mask 001 00000007
W euen_w 002 ffffffff
R euen_mask 002 00000001
W ecfg_w 004 ffffffff
R ecfg_mask 004 00001bff
W estat_w 005 ffffffff
R estat_mask 005 00000003
W eentry_w 00c ffffffff
R eentry_mask 00c ffffffc0
W save2_w 032 ffffffff
R save2_mask 032 ffffffff
W cpuid_w 020 ffffffff
R cpuid_ro 020 00000005
R ticlr_rd 044 00000000
R unimpl_rd 003 00000000
W ecfg_clr 004 00000000
W estat_clr 005 00000000
W crmd_set 000 00000007
W eentry_set 00c 1c008000
C sys 1c000100 1 8 00000000 0b
R prmd_sys 001 00000007
R crmd_sys 000 00000000
P plv_sys 0
C ale 1c000200 1 7 deadbeef 09
C adef 1c000300 1 5 00000000 08
C adem 1c000400 1 6 12345678 08
L llsc_set 1
B llbit_set 1
W prmd_ret 001 00000006
W era_ret 006 1c000500
E ertn
P plv_ertn 2
R crmd_ertn 000 00000006
B llbit_ertn 0
L llsc_set2 1
W klo_set 060 00000004
R llbctl_klo 060 00000005
E ertn_klo
B llbit_klo 1
R llbctl_ret 060 00000001
W wcllb 060 00000002
B llbit_wcllb 0
H hwi3 08 0
R estat_hwi 005 00480020
W ecfg_int 004 00000020
C int 1c000600 1 a 00000000 00
C ine 1c000700 1 a 00000000 0d
H hwi_clr 00 0
W tcfg_one 041 00000011
T ti_one 40
N tval_hold 4
R tval_zero 042 00000000
W ticlr 044 00000001
N ti_clear 1
R estat_ticlr 005 000d0000
W tcfg_per 041 00000013
T ti_per1 40
W ticlr_per 044 00000001
N ti_clear2 2
R estat_per 005 000d0000
T ti_per2 40

//--- sim/csr_unit_tb.sv
module csr_unit_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import csr_pkg::*;

    logic       clk;
    logic       rst;
    commit_t    commit;
    logic       ertn;
    csr_wr_t    csr_wr;
    logic       rd_en;
    csr_addr_t  rd_addr;
    logic [7:0] hwi;
    logic       ipi;
    word_t      rd_data;
    redirect_t  redirect;
    logic [1:0] plv;
    logic       llbit;

    int    errors;
    int    checks;
    word_t m_eentry;  // Reference copies of EENTRY, ERA, BADV
    word_t m_era;
    word_t m_badv;

    csr_unit #(
        .CORE_ID(5)
    ) csr_unit_i (
        .clk          (clk),
        .rst          (rst),
        .commit_i     (commit),
        .ertn_i       (ertn),
        .csr_wr_i     (csr_wr),
        .csr_rd_en_i  (rd_en),
        .csr_rd_addr_i(rd_addr),
        .hwi_i        (hwi),
        .ipi_i        (ipi),
        .csr_rd_data_o(rd_data),
        .redirect_o   (redirect),
        .plv_o        (plv),
        .llbit_o      (llbit)
    );

    always #4 clk = ~clk;

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string name, input word_t exp, input word_t act);
        checks++;
        if (exp !== act) begin
            $display("Error %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    // Sample the combinational read port mid-cycle
    task automatic read_csr(input csr_addr_t addr, output word_t data);
        rd_en = 1'b1;
        rd_addr = addr;
        @(negedge clk);
        data = rd_data;
        next_cycle();
        rd_en = 1'b0;
    endtask

    task automatic write_csr(input csr_addr_t addr, input word_t data, input logic llsc);
        csr_wr.en = 1'b1;
        csr_wr.addr = addr;
        csr_wr.data = data;
        csr_wr.is_llsc = llsc;
        next_cycle();
        csr_wr.en = 1'b0;
        csr_wr.is_llsc = 1'b0;
        if (!llsc) begin
            case (addr)
                CSR_ERA:    m_era = data;
                CSR_BADV:   m_badv = data;
                CSR_EENTRY: m_eentry = {data[31:6], 6'd0};
                default:    ;
            endcase
        end
    endtask

    task automatic wait_redirect(input string name, input word_t exp_target);
        int   n;
        logic seen;
        seen = 1'b0;
        for (n = 0; n < 8 && !seen; n++) begin
            @(negedge clk);
            if (redirect.valid) begin
                seen = 1'b1;
                check_value({name, "_delay"}, 32'd0, 32'(n));  // One cycle after the strobe
                check_value({name, "_target"}, exp_target, redirect.target);
            end
            next_cycle();
        end
        if (!seen) begin
            $display("Timeout: no redirect pulse seen after %s", name);
            errors++;
        end else begin
            @(negedge clk);
            check_value({name, "_pulse"}, 32'd0, 32'(redirect.valid));  // Single cycle only
            next_cycle();
        end
    endtask

    task automatic do_commit(input string name, input word_t pc, input logic exc,
                             input cause_t cause, input word_t badv, input ecode_t ecode);
        logic  intr;
        word_t target;
        word_t data;
        intr = (ecode == 6'd0);  // Interrupt expected
        target = m_eentry;
        commit.valid = 1'b1;
        commit.pc = pc;
        commit.exc_valid = exc;
        commit.cause = cause;
        commit.badv = badv;
        next_cycle();
        commit.valid = 1'b0;
        commit.exc_valid = 1'b0;
        m_era = (!intr && (cause == CAUSE_SYS || cause == CAUSE_BRK)) ? pc + 32'd4 : pc;
        if (!intr && cause == CAUSE_ADEF) begin
            m_badv = pc;
        end else if (!intr && cause inside {CAUSE_PIL, CAUSE_PIS, CAUSE_PIF, CAUSE_PME,
                                            CAUSE_PPI, CAUSE_ALE}) begin
            m_badv = badv;
        end
        wait_redirect(name, target);
        read_csr(CSR_ESTAT, data);
        check_value({name, "_ecode"}, 32'(ecode), 32'(data[21:16]));
        check_value({name, "_esubcode"}, (!intr && cause == CAUSE_ADEM) ? 32'd1 : 32'd0,
                    32'(data[30:22]));
        read_csr(CSR_ERA, data);
        check_value({name, "_era"}, m_era, data);
        read_csr(CSR_BADV, data);
        check_value({name, "_badv"}, m_badv, data);
    endtask

    task automatic do_ertn(input string name);
        word_t target;
        target = m_era;
        ertn = 1'b1;
        next_cycle();
        ertn = 1'b0;
        wait_redirect(name, target);
    endtask

    // Poll ESTAT.TI
    task automatic wait_ti(input string name, input int limit);
        int    n;
        logic  seen;
        word_t data;
        seen = 1'b0;
        for (n = 0; n < limit && !seen; n++) begin
            read_csr(CSR_ESTAT, data);
            seen = data[11];
        end
        if (!seen) begin
            $display("Timeout: timer interrupt never showed up in %s", name);
            errors++;
        end
    endtask

    initial begin
        int    fd;
        int    cnt;
        string line_s;
        string op;
        string name;
        word_t a0;
        word_t a1;
        word_t a2;
        word_t a3;
        word_t a4;
        word_t data;
        clk = 1'b0;
        rst = 1'b1;
        commit = '0;
        ertn = 1'b0;
        csr_wr = '0;
        rd_en = 1'b0;
        rd_addr = '0;
        hwi = '0;
        ipi = 1'b0;
        errors = 0;
        checks = 0;
        m_eentry = '0;
        m_era = '0;
        m_badv = '0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        check_value("redirect_rst", 32'd0, 32'(redirect.valid));

        fd = $fopen("sim/csr_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the case file sim/csr_cases.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line_s = "";
                cnt = $fgets(line_s, fd);
                if (cnt <= 1 || line_s[0] == "#") continue;
                cnt = $sscanf(line_s, "%s %s %h %h %h %h %h", op, name, a0, a1, a2, a3, a4);
                case (line_s[0])
                    "W": write_csr(csr_addr_t'(a0), a1, 1'b0);
                    "L": write_csr(CSR_LLBCTL, a0, 1'b1);
                    "R": begin
                        read_csr(csr_addr_t'(a0), data);
                        check_value(name, a1, data);
                    end
                    "C": do_commit(name, a0, a1[0], cause_t'(a2), a3, ecode_t'(a4));
                    "E": do_ertn(name);
                    "H": begin
                        hwi = a0[7:0];
                        ipi = a1[0];
                        next_cycle();
                    end
                    "T": wait_ti(name, int'(a0));
                    "N": repeat (int'(a0)) next_cycle();
                    "P": check_value(name, a0, 32'(plv));
                    "B": check_value(name, a0, 32'(llbit));
                    default: begin
                        $display("Unknown operation %s in case %s", op, name);
                        errors++;
                    end
                endcase
            end
            $fclose(fd);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
